//--- verilog/vram_pkg.sv
// sizes and field types of the shared register RAM, referenced by scoped name from RTL and testbench
package vram_pkg;

    // ==========================================================
    // array geometry
    // ==========================================================

    localparam int VRAM_WIDTH    = 32;
    localparam int VRAM_DEPTH    = 16;
    localparam int VRAM_ADDR_W   = $clog2(VRAM_DEPTH);
    localparam int VRAM_BE_COUNT = 4;

    // one lane per byte enable
    localparam int VRAM_BWIDTH   = VRAM_WIDTH / VRAM_BE_COUNT;

    // ==========================================================
    // clients
    // ==========================================================

    localparam int NUM_CLIENTS   = 2;
    localparam int CLIENT_ID_W   = $clog2(NUM_CLIENTS);

    // ==========================================================
    // field types
    // ==========================================================

    typedef logic [VRAM_WIDTH-1:0]    vram_data_t;
    typedef logic [VRAM_ADDR_W-1:0]   vram_addr_t;
    typedef logic [VRAM_BE_COUNT-1:0] vram_be_t;

    // index of a client, also the round-robin pointer
    typedef logic [CLIENT_ID_W-1:0]   client_id_t;

endpackage

//--- verilog/vram_storage.sv
// byte-lane flop array with reset clear, combinational read and snapshot, used under the arbiter
`timescale 1ns/100ps

module vram_storage (
    input  logic                                             vram_clock,
    input  logic                                             sync_reset_enable_int,
    input  logic                                             write_enable,
    input  vram_pkg::vram_addr_t                             write_address,
    input  vram_pkg::vram_data_t                             write_data,
    input  vram_pkg::vram_be_t                               write_byte_enable,
    input  vram_pkg::vram_addr_t                             read_address,
    output vram_pkg::vram_data_t                             read_data,
    output vram_pkg::vram_data_t                             write_data_flopped,
    output logic [vram_pkg::VRAM_WIDTH*vram_pkg::VRAM_DEPTH-1:0] data_memory
);

    // storage split into byte lanes
    logic [vram_pkg::VRAM_BWIDTH-1:0] mem
        [vram_pkg::VRAM_DEPTH][vram_pkg::VRAM_BE_COUNT];

    vram_pkg::vram_data_t write_data_final;
    vram_pkg::vram_be_t   lane_enable;
    logic                 entry_select [vram_pkg::VRAM_DEPTH];

    // ==========================================================
    // write side
    // ==========================================================

    // reset turns every lane of every entry on with zero data
    always_comb begin
        if (sync_reset_enable_int) begin
            write_data_final = '0;
            lane_enable      = '1;
        end else begin
            write_data_final = write_data;
            lane_enable      = write_enable ? write_byte_enable : '0;
        end
    end

    // address decode, all entries selected while in reset
    always_comb begin
        for (int d = 0; d < vram_pkg::VRAM_DEPTH; d++) begin
            entry_select[d] = sync_reset_enable_int ||
                              (write_address == vram_pkg::vram_addr_t'(d));
        end
    end

    always_ff @(posedge vram_clock) begin
        for (int d = 0; d < vram_pkg::VRAM_DEPTH; d++) begin
            for (int b = 0; b < vram_pkg::VRAM_BE_COUNT; b++) begin
                if (entry_select[d] && lane_enable[b]) begin
                    mem[d][b] <= write_data_final[b*vram_pkg::VRAM_BWIDTH +: vram_pkg::VRAM_BWIDTH];
                end
            end
        end
    end

    // copy of the accepted lanes, visible one cycle after the write
    always_ff @(posedge vram_clock) begin
        for (int b = 0; b < vram_pkg::VRAM_BE_COUNT; b++) begin
            if (lane_enable[b]) begin
                write_data_flopped[b*vram_pkg::VRAM_BWIDTH +: vram_pkg::VRAM_BWIDTH] <=
                    write_data_final[b*vram_pkg::VRAM_BWIDTH +: vram_pkg::VRAM_BWIDTH];
            end
        end
    end

    // ==========================================================
    // read side
    // ==========================================================

    always_comb begin
        for (int b = 0; b < vram_pkg::VRAM_BE_COUNT; b++) begin
            read_data[b*vram_pkg::VRAM_BWIDTH +: vram_pkg::VRAM_BWIDTH] = mem[read_address][b];
        end
    end

    // whole array flattened, entry 0 in the low word
    always_comb begin
        for (int d = 0; d < vram_pkg::VRAM_DEPTH; d++) begin
            for (int b = 0; b < vram_pkg::VRAM_BE_COUNT; b++) begin
                data_memory[d*vram_pkg::VRAM_WIDTH + b*vram_pkg::VRAM_BWIDTH +:
                            vram_pkg::VRAM_BWIDTH] = mem[d][b];
            end
        end
    end

    // a write must target a real entry
    assert property (@(posedge vram_clock) disable iff (sync_reset_enable_int)
        write_enable |-> (int'(write_address) < vram_pkg::VRAM_DEPTH))
        else $error("vram write address out of range");

endmodule

//--- verilog/vram_arbiter.sv
// round-robin arbiter between the client ports, drives the storage and steers read returns
`timescale 1ns/100ps

module vram_arbiter (
    input  logic                                 vram_clock,
    input  logic                                 sync_reset_enable_int,
    input  logic [vram_pkg::NUM_CLIENTS-1:0]     pend,
    input  logic [vram_pkg::NUM_CLIENTS-1:0]     pend_wr,
    input  vram_pkg::vram_addr_t                 pend_addr  [vram_pkg::NUM_CLIENTS],
    input  vram_pkg::vram_data_t                 pend_wdata [vram_pkg::NUM_CLIENTS],
    input  vram_pkg::vram_be_t                   pend_be    [vram_pkg::NUM_CLIENTS],
    output logic [vram_pkg::NUM_CLIENTS-1:0]     gnt,
    output logic [vram_pkg::NUM_CLIENTS-1:0]     rsp_valid,
    output vram_pkg::vram_data_t                 rsp_data   [vram_pkg::NUM_CLIENTS],
    output logic                                 write_enable,
    output vram_pkg::vram_addr_t                 write_address,
    output vram_pkg::vram_data_t                 write_data,
    output vram_pkg::vram_be_t                   write_byte_enable,
    output vram_pkg::vram_addr_t                 read_address,
    input  vram_pkg::vram_data_t                 read_data
);

    vram_pkg::client_id_t last_gnt;
    vram_pkg::client_id_t win_id;
    vram_pkg::client_id_t cand;
    logic                 any_gnt;

    // read return stage
    logic                 rsp_valid_q;
    vram_pkg::client_id_t rsp_id_q;
    vram_pkg::vram_data_t rsp_data_q;

    // ==========================================================
    // round-robin selection
    // ==========================================================

    // search starts one past the client granted last
    always_comb begin
        any_gnt = 1'b0;
        win_id  = last_gnt;
        for (int k = 1; k <= vram_pkg::NUM_CLIENTS; k++) begin
            cand = vram_pkg::client_id_t'((int'(last_gnt) + k) % vram_pkg::NUM_CLIENTS);
            if (!any_gnt && pend[cand]) begin
                any_gnt = 1'b1;
                win_id  = cand;
            end
        end
        gnt = '0;
        if (any_gnt) begin
            gnt[win_id] = 1'b1;
        end
    end

    // winner's fields into the array
    always_comb begin
        write_enable      = any_gnt && pend_wr[win_id];
        write_address     = pend_addr[win_id];
        write_data        = pend_wdata[win_id];
        write_byte_enable = pend_be[win_id];
        read_address      = pend_addr[win_id];
    end

    // ==========================================================
    // pointer and read return
    // ==========================================================

    // pointer starts on the last client so client 0 takes the first tie
    always_ff @(posedge vram_clock) begin
        if (sync_reset_enable_int) begin
            last_gnt    <= vram_pkg::client_id_t'(vram_pkg::NUM_CLIENTS - 1);
            rsp_valid_q <= 1'b0;
        end else begin
            if (any_gnt) begin
                last_gnt <= win_id;
            end
            rsp_valid_q <= any_gnt && !pend_wr[win_id];
        end
    end

    always_ff @(posedge vram_clock) begin
        if (any_gnt && !pend_wr[win_id]) begin
            rsp_id_q   <= win_id;
            rsp_data_q <= read_data;
        end
    end

    // only the requester sees the valid
    always_comb begin
        for (int k = 0; k < vram_pkg::NUM_CLIENTS; k++) begin
            rsp_valid[k] = rsp_valid_q && (rsp_id_q == vram_pkg::client_id_t'(k));
            rsp_data[k]  = rsp_data_q;
        end
    end

    assert property (@(posedge vram_clock) disable iff (sync_reset_enable_int)
        $onehot0(gnt))
        else $error("vram arbiter granted more than one client");

    assert property (@(posedge vram_clock) disable iff (sync_reset_enable_int)
        (gnt & ~pend) == '0)
        else $error("vram arbiter granted a client with nothing pending");

endmodule

//--- verilog/vram_client_port.sv
// per-client request holder, presents one pending request to the arbiter and returns the result
`timescale 1ns/100ps

module vram_client_port (
    input  logic                 vram_clock,
    input  logic                 sync_reset_enable_int,
    input  logic                 req,
    input  logic                 wr,
    input  vram_pkg::vram_addr_t addr,
    input  vram_pkg::vram_data_t wdata,
    input  vram_pkg::vram_be_t   be,
    input  logic                 gnt,
    input  logic                 rsp_valid,
    input  vram_pkg::vram_data_t rsp_data,
    output logic                 pend,
    output logic                 pend_wr,
    output vram_pkg::vram_addr_t pend_addr,
    output vram_pkg::vram_data_t pend_wdata,
    output vram_pkg::vram_be_t   pend_be,
    output logic                 busy,
    output logic                 gnt_out,
    output logic                 rvalid,
    output logic [vram_pkg::VRAM_WIDTH-1:0] rdata
);

    logic capture;

    // ==========================================================
    // request holding
    // ==========================================================

    // a strobe while something is pending is dropped
    assign capture = req && !pend;

    always_ff @(posedge vram_clock) begin
        if (sync_reset_enable_int) begin
            pend <= 1'b0;
        end else if (capture) begin
            pend <= 1'b1;
        end else if (gnt) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge vram_clock) begin
        if (capture) begin
            pend_wr    <= wr;
            pend_addr  <= addr;
            pend_wdata <= wdata;
            pend_be    <= be;
        end
    end

    // busy from the strobe until the grant cycle ends
    assign busy = req || pend;

    // ==========================================================
    // outward grant and read return
    // ==========================================================

    assign gnt_out = gnt;
    assign rvalid  = rsp_valid;
    assign rdata   = rsp_data;

    assert property (@(posedge vram_clock) disable iff (sync_reset_enable_int)
        gnt |-> pend)
        else $error("vram client port granted while idle");

    // a granted read comes back exactly one cycle later
    assert property (@(posedge vram_clock) disable iff (sync_reset_enable_int)
        (gnt && !pend_wr) |=> rsp_valid)
        else $error("vram read return missing after grant");

endmodule

//--- verilog/vram_subsys_top.sv
// top of the shared register RAM, two client ports through the arbiter into one storage array
`timescale 1ns/100ps

module vram_subsys_top (
    input  logic                 vram_clock,
    input  logic                 sync_reset_enable_int,
    // client 0
    input  logic                 c0_req,
    input  logic                 c0_wr,
    input  vram_pkg::vram_addr_t c0_addr,
    input  vram_pkg::vram_data_t c0_wdata,
    input  vram_pkg::vram_be_t   c0_be,
    output logic                 c0_gnt,
    output logic                 c0_busy,
    output logic                 c0_rvalid,
    output vram_pkg::vram_data_t c0_rdata,
    // client 1
    input  logic                 c1_req,
    input  logic                 c1_wr,
    input  vram_pkg::vram_addr_t c1_addr,
    input  vram_pkg::vram_data_t c1_wdata,
    input  vram_pkg::vram_be_t   c1_be,
    output logic                 c1_gnt,
    output logic                 c1_busy,
    output logic                 c1_rvalid,
    output vram_pkg::vram_data_t c1_rdata,
    // observation
    output logic [vram_pkg::VRAM_WIDTH*vram_pkg::VRAM_DEPTH-1:0] data_memory,
    output vram_pkg::vram_data_t write_data_flopped
);

    logic [vram_pkg::NUM_CLIENTS-1:0] pend;
    logic [vram_pkg::NUM_CLIENTS-1:0] pend_wr;
    logic [vram_pkg::NUM_CLIENTS-1:0] gnt;
    logic [vram_pkg::NUM_CLIENTS-1:0] rsp_valid;
    vram_pkg::vram_addr_t             pend_addr  [vram_pkg::NUM_CLIENTS];
    vram_pkg::vram_data_t             pend_wdata [vram_pkg::NUM_CLIENTS];
    vram_pkg::vram_be_t               pend_be    [vram_pkg::NUM_CLIENTS];
    vram_pkg::vram_data_t             rsp_data   [vram_pkg::NUM_CLIENTS];

    // arbiter to storage
    logic                 write_enable;
    vram_pkg::vram_addr_t write_address;
    vram_pkg::vram_data_t write_data;
    vram_pkg::vram_be_t   write_byte_enable;
    vram_pkg::vram_addr_t read_address;
    vram_pkg::vram_data_t read_data;

    // ==========================================================
    // client ports
    // ==========================================================

    vram_client_port u_port0 (
        .vram_clock            (vram_clock),
        .sync_reset_enable_int (sync_reset_enable_int),
        .req                   (c0_req),
        .wr                    (c0_wr),
        .addr                  (c0_addr),
        .wdata                 (c0_wdata),
        .be                    (c0_be),
        .gnt                   (gnt[0]),
        .rsp_valid             (rsp_valid[0]),
        .rsp_data              (rsp_data[0]),
        .pend                  (pend[0]),
        .pend_wr               (pend_wr[0]),
        .pend_addr             (pend_addr[0]),
        .pend_wdata            (pend_wdata[0]),
        .pend_be               (pend_be[0]),
        .busy                  (c0_busy),
        .gnt_out               (c0_gnt),
        .rvalid                (c0_rvalid),
        .rdata                 (c0_rdata)
    );

    vram_client_port u_port1 (
        .vram_clock            (vram_clock),
        .sync_reset_enable_int (sync_reset_enable_int),
        .req                   (c1_req),
        .wr                    (c1_wr),
        .addr                  (c1_addr),
        .wdata                 (c1_wdata),
        .be                    (c1_be),
        .gnt                   (gnt[1]),
        .rsp_valid             (rsp_valid[1]),
        .rsp_data              (rsp_data[1]),
        .pend                  (pend[1]),
        .pend_wr               (pend_wr[1]),
        .pend_addr             (pend_addr[1]),
        .pend_wdata            (pend_wdata[1]),
        .pend_be               (pend_be[1]),
        .busy                  (c1_busy),
        .gnt_out               (c1_gnt),
        .rvalid                (c1_rvalid),
        .rdata                 (c1_rdata)
    );

    // ==========================================================
    // arbiter and array
    // ==========================================================

    vram_arbiter u_arbiter (
        .vram_clock            (vram_clock),
        .sync_reset_enable_int (sync_reset_enable_int),
        .pend                  (pend),
        .pend_wr               (pend_wr),
        .pend_addr             (pend_addr),
        .pend_wdata            (pend_wdata),
        .pend_be               (pend_be),
        .gnt                   (gnt),
        .rsp_valid             (rsp_valid),
        .rsp_data              (rsp_data),
        .write_enable          (write_enable),
        .write_address         (write_address),
        .write_data            (write_data),
        .write_byte_enable     (write_byte_enable),
        .read_address          (read_address),
        .read_data             (read_data)
    );

    vram_storage u_storage (
        .vram_clock            (vram_clock),
        .sync_reset_enable_int (sync_reset_enable_int),
        .write_enable          (write_enable),
        .write_address         (write_address),
        .write_data            (write_data),
        .write_byte_enable     (write_byte_enable),
        .read_address          (read_address),
        .read_data             (read_data),
        .write_data_flopped    (write_data_flopped),
        .data_memory           (data_memory)
    );

endmodule

//--- dv/tb_clock_gen.sv
// clock and reset source for the vram testbench, 20 ns period with reset held for two cycles
`timescale 1ns/100ps

module tb_clock_gen (
    output logic vram_clock,
    output logic sync_reset_enable_int
);

    localparam real HALF_PERIOD = 10.0;

    initial begin
        vram_clock = 1'b0;
        forever begin
            #(HALF_PERIOD) vram_clock = ~vram_clock;
        end
    end

    // synchronous reset, released on the second rising edge
    initial begin
        sync_reset_enable_int = 1'b1;
        repeat (2) @(posedge vram_clock);
        sync_reset_enable_int <= 1'b0;
    end

endmodule

//--- dv/vram_subsys_tb.sv
// directed testbench for the shared register RAM, runs every test against a byte-merge model
`timescale 1ns/100ps

module vram_subsys_tb;

    // worst case cycles for one request, from the busy wait to the read return
    localparam int REQ_CYCLES  = 8;
    localparam int NUM_REQS    = 2 + 16 + 32 + 10 + 4 + 1 + 4 + 200;
    localparam int CYCLE_LIMIT = NUM_REQS * REQ_CYCLES + 200;

    logic                 vram_clock;
    logic                 sync_reset_enable_int;
    logic                 c0_req;
    logic                 c0_wr;
    vram_pkg::vram_addr_t c0_addr;
    vram_pkg::vram_data_t c0_wdata;
    vram_pkg::vram_be_t   c0_be;
    logic                 c0_gnt;
    logic                 c0_busy;
    logic                 c0_rvalid;
    vram_pkg::vram_data_t c0_rdata;
    logic                 c1_req;
    logic                 c1_wr;
    vram_pkg::vram_addr_t c1_addr;
    vram_pkg::vram_data_t c1_wdata;
    vram_pkg::vram_be_t   c1_be;
    logic                 c1_gnt;
    logic                 c1_busy;
    logic                 c1_rvalid;
    vram_pkg::vram_data_t c1_rdata;
    logic [vram_pkg::VRAM_WIDTH*vram_pkg::VRAM_DEPTH-1:0] data_memory;
    vram_pkg::vram_data_t write_data_flopped;

    vram_pkg::vram_data_t model_mem [vram_pkg::VRAM_DEPTH];
    int                   last_winner;
    int                   error_count;
    int                   cycle_count;
    logic [31:0]          lfsr_state;

    tb_clock_gen u_clock_gen (
        .vram_clock            (vram_clock),
        .sync_reset_enable_int (sync_reset_enable_int)
    );

    vram_subsys_top uut (
        .vram_clock            (vram_clock),
        .sync_reset_enable_int (sync_reset_enable_int),
        .c0_req                (c0_req),
        .c0_wr                 (c0_wr),
        .c0_addr               (c0_addr),
        .c0_wdata              (c0_wdata),
        .c0_be                 (c0_be),
        .c0_gnt                (c0_gnt),
        .c0_busy               (c0_busy),
        .c0_rvalid             (c0_rvalid),
        .c0_rdata              (c0_rdata),
        .c1_req                (c1_req),
        .c1_wr                 (c1_wr),
        .c1_addr               (c1_addr),
        .c1_wdata              (c1_wdata),
        .c1_be                 (c1_be),
        .c1_gnt                (c1_gnt),
        .c1_busy               (c1_busy),
        .c1_rvalid             (c1_rvalid),
        .c1_rdata              (c1_rdata),
        .data_memory           (data_memory),
        .write_data_flopped    (write_data_flopped)
    );

    // ==========================================================
    // compare tasks, model and random source
    // ==========================================================

    task automatic check_data(input string name, input vram_pkg::vram_data_t got,
                              input vram_pkg::vram_data_t exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // only the enabled byte lanes take the new data
    function automatic vram_pkg::vram_data_t merge_bytes(input vram_pkg::vram_data_t old,
                                                         input vram_pkg::vram_data_t d,
                                                         input vram_pkg::vram_be_t be);
        vram_pkg::vram_data_t r;
        r = old;
        for (int b = 0; b < vram_pkg::VRAM_BE_COUNT; b++) begin
            if (be[b]) begin
                r[b*vram_pkg::VRAM_BWIDTH +: vram_pkg::VRAM_BWIDTH] =
                    d[b*vram_pkg::VRAM_BWIDTH +: vram_pkg::VRAM_BWIDTH];
            end
        end
        return r;
    endfunction

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // ==========================================================
    // per-client access
    // ==========================================================

    function automatic logic get_gnt(input int c);
        return (c == 0) ? c0_gnt : c1_gnt;
    endfunction

    function automatic logic get_busy(input int c);
        return (c == 0) ? c0_busy : c1_busy;
    endfunction

    function automatic logic get_rvalid(input int c);
        return (c == 0) ? c0_rvalid : c1_rvalid;
    endfunction

    function automatic vram_pkg::vram_data_t get_rdata(input int c);
        return (c == 0) ? c0_rdata : c1_rdata;
    endfunction

    task automatic drive_req(input int c, input logic wr, input vram_pkg::vram_addr_t a,
                             input vram_pkg::vram_data_t d, input vram_pkg::vram_be_t be);
        if (c == 0) begin
            c0_req   <= 1'b1;
            c0_wr    <= wr;
            c0_addr  <= a;
            c0_wdata <= d;
            c0_be    <= be;
        end else begin
            c1_req   <= 1'b1;
            c1_wr    <= wr;
            c1_addr  <= a;
            c1_wdata <= d;
            c1_be    <= be;
        end
    endtask

    task automatic clear_req(input int c);
        if (c == 0) begin
            c0_req <= 1'b0;
        end else begin
            c1_req <= 1'b0;
        end
    endtask

    // one strobe, wait for the grant, then check the result in the cycle after it
    task automatic do_request(input int c, input logic wr, input vram_pkg::vram_addr_t a,
                              input vram_pkg::vram_data_t d, input vram_pkg::vram_be_t be);
        vram_pkg::vram_data_t expected;
        @(negedge vram_clock);
        while (get_busy(c)) begin
            @(negedge vram_clock);
        end
        @(posedge vram_clock);
        drive_req(c, wr, a, d, be);
        @(posedge vram_clock);
        clear_req(c);
        @(negedge vram_clock);
        while (!get_gnt(c)) begin
            @(negedge vram_clock);
        end
        check_bit($sformatf("c%0d_gnt", 1 - c), get_gnt(1 - c), 1'b0);
        // busy lasts through the grant cycle, the return comes only after it
        check_bit($sformatf("c%0d_busy", c), get_busy(c), 1'b1);
        check_bit($sformatf("c%0d_rvalid", c), get_rvalid(c), 1'b0);
        last_winner = c;
        if (wr) begin
            model_mem[a] = merge_bytes(model_mem[a], d, be);
        end
        expected = model_mem[a];
        @(negedge vram_clock);
        check_bit($sformatf("c%0d_gnt", c), get_gnt(c), 1'b0);
        check_bit($sformatf("c%0d_busy", c), get_busy(c), 1'b0);
        check_bit($sformatf("c%0d_rvalid", c), get_rvalid(c), !wr);
        if (!wr) begin
            check_data($sformatf("c%0d_rdata", c), get_rdata(c), expected);
        end else begin
            check_data($sformatf("data_memory[%0d]", a),
                       data_memory[int'(a)*vram_pkg::VRAM_WIDTH +: vram_pkg::VRAM_WIDTH],
                       expected);
            if (be == '1) begin
                check_data("write_data_flopped", write_data_flopped, d);
            end
        end
    endtask

    // both clients read in the same cycle, the one not granted last goes first
    task automatic tie_reads(input vram_pkg::vram_addr_t a0, input vram_pkg::vram_addr_t a1);
        vram_pkg::vram_addr_t addr_of [2];
        int w;
        int l;
        addr_of[0] = a0;
        addr_of[1] = a1;
        w = 1 - last_winner;
        l = last_winner;
        @(negedge vram_clock);
        while (c0_busy || c1_busy) begin
            @(negedge vram_clock);
        end
        @(posedge vram_clock);
        drive_req(0, 1'b0, a0, '0, '1);
        drive_req(1, 1'b0, a1, '0, '1);
        @(posedge vram_clock);
        clear_req(0);
        clear_req(1);
        @(negedge vram_clock);
        check_bit($sformatf("c%0d_gnt", w), get_gnt(w), 1'b1);
        check_bit($sformatf("c%0d_gnt", l), get_gnt(l), 1'b0);
        @(negedge vram_clock);
        check_bit($sformatf("c%0d_gnt", l), get_gnt(l), 1'b1);
        check_bit($sformatf("c%0d_gnt", w), get_gnt(w), 1'b0);
        check_bit($sformatf("c%0d_rvalid", w), get_rvalid(w), 1'b1);
        check_bit($sformatf("c%0d_rvalid", l), get_rvalid(l), 1'b0);
        check_data($sformatf("c%0d_rdata", w), get_rdata(w), model_mem[addr_of[w]]);
        @(negedge vram_clock);
        check_bit($sformatf("c%0d_rvalid", l), get_rvalid(l), 1'b1);
        check_bit($sformatf("c%0d_rvalid", w), get_rvalid(w), 1'b0);
        check_data($sformatf("c%0d_rdata", l), get_rdata(l), model_mem[addr_of[l]]);
        last_winner = l;
    endtask

    // ==========================================================
    // directed tests
    // ==========================================================

    task automatic test_reset_clear();
        while (sync_reset_enable_int) begin
            @(posedge vram_clock);
        end
        @(negedge vram_clock);
        for (int c = 0; c < 2; c++) begin
            check_bit($sformatf("c%0d_gnt", c), get_gnt(c), 1'b0);
            check_bit($sformatf("c%0d_busy", c), get_busy(c), 1'b0);
            check_bit($sformatf("c%0d_rvalid", c), get_rvalid(c), 1'b0);
        end
        // first tie after reset goes to client 0
        tie_reads(4'd0, 4'd15);
        for (int a = 0; a < vram_pkg::VRAM_DEPTH; a++) begin
            do_request(0, 1'b0, vram_pkg::vram_addr_t'(a), '0, '1);
        end
    endtask

    task automatic test_full_write_read();
        for (int a = 0; a < vram_pkg::VRAM_DEPTH; a++) begin
            do_request(0, 1'b1, vram_pkg::vram_addr_t'(a),
                       {8'hc3, 4'(a), 4'(~a), 16'h5a00 + 16'(a * 37)}, '1);
            do_request(0, 1'b0, vram_pkg::vram_addr_t'(a), '0, '1);
        end
    endtask

    task automatic test_byte_enables();
        do_request(0, 1'b1, 4'd3, 32'h1122_3344, '1);
        do_request(0, 1'b1, 4'd3, 32'haaaa_aaaa, 4'b0001);
        do_request(0, 1'b0, 4'd3, '0, '1);
        do_request(0, 1'b1, 4'd3, 32'hbbbb_bbbb, 4'b0100);
        do_request(0, 1'b0, 4'd3, '0, '1);
        do_request(0, 1'b1, 4'd3, 32'hcccc_cccc, 4'b1010);
        do_request(0, 1'b0, 4'd3, '0, '1);
        do_request(1, 1'b1, 4'd12, 32'hdead_beef, 4'b0110);
        do_request(1, 1'b1, 4'd12, 32'h0f0f_0f0f, 4'b1001);
        do_request(1, 1'b0, 4'd12, '0, '1);
    endtask

    // client 1 was granted last, then client 0, so each side wins one tie
    task automatic test_contention();
        tie_reads(4'd1, 4'd3);
        do_request(0, 1'b0, 4'd1, '0, '1);
        tie_reads(4'd12, 4'd7);
    endtask

    task automatic test_sharing();
        do_request(1, 1'b1, 4'd5, 32'h0bad_f00d, '1);
        do_request(0, 1'b0, 4'd5, '0, '1);
        do_request(0, 1'b1, 4'd9, 32'h7654_3210, '1);
        do_request(1, 1'b0, 4'd9, '0, '1);
    endtask

    task automatic test_random_traffic();
        int c;
        logic wr;
        vram_pkg::vram_addr_t a;
        vram_pkg::vram_data_t d;
        vram_pkg::vram_be_t be;
        for (int n = 0; n < 200; n++) begin
            c  = int'(take_bits(1));
            wr = 1'(take_bits(1));
            a  = vram_pkg::vram_addr_t'(take_bits(vram_pkg::VRAM_ADDR_W));
            d  = take_bits(vram_pkg::VRAM_WIDTH);
            be = vram_pkg::vram_be_t'(take_bits(vram_pkg::VRAM_BE_COUNT));
            do_request(c, wr, a, d, be);
        end
    endtask

    // ==========================================================
    // run control
    // ==========================================================

    always @(posedge vram_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    initial begin
        c0_req      = 1'b0;
        c0_wr       = 1'b0;
        c0_addr     = '0;
        c0_wdata    = '0;
        c0_be       = '0;
        c1_req      = 1'b0;
        c1_wr       = 1'b0;
        c1_addr     = '0;
        c1_wdata    = '0;
        c1_be       = '0;
        cycle_count = 0;
        error_count = 0;
        lfsr_state  = 32'h5df9;
        // pointer after reset lets client 0 take the first tie
        last_winner = 1;
        for (int a = 0; a < vram_pkg::VRAM_DEPTH; a++) begin
            model_mem[a] = '0;
        end

        test_reset_clear();
        test_full_write_read();
        test_byte_enables();
        test_contention();
        test_sharing();
        test_random_traffic();

        @(negedge vram_clock);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
verilog/vram_pkg.sv
verilog/vram_storage.sv
verilog/vram_arbiter.sv
verilog/vram_client_port.sv
verilog/vram_subsys_top.sv
dv/tb_clock_gen.sv
dv/vram_subsys_tb.sv
